// ==== filelist.f ====
+incdir+rtl
rtl/copper_pkg.sv
rtl/copper_list_ram.sv
rtl/copper_decode.sv
rtl/copper_execute.sv
rtl/copper_result.sv
rtl/copper_top.sv
verification/tb_copper_top.sv

// ==== verification/tb_copper_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the copper top level
// Loads programs, steers the beam counts and checks every XR write
// against a reference model of the instruction set
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "copper_defines.svh"

module tb_copper_top;

    localparam int RESTART_H = `COPPER_H_TOTAL - `COPPER_RESTART_H_OFFSET;
    localparam int RESTART_V = `COPPER_V_TOTAL - 1;
    // WAIT at (0,0) with both ignore flags parks the copper until restart
    localparam copper_pkg::insn_word_t HALT_WORD = 32'h0000_0003;

    logic                   clk;
    logic                   copp_reset;
    logic                   list_wr_en;
    copper_pkg::pc_t        list_wr_addr;
    copper_pkg::insn_word_t list_wr_data;
    copper_pkg::ctrl_wr_t   ctrl_wr;
    copper_pkg::pos_t       h_cnt;
    copper_pkg::pos_t       v_cnt;
    logic                   xr_reg_busy;
    logic                   color_busy;
    copper_pkg::xr_wr_t     xr_wr;

    integer                 seed;
    logic                   busy_on;
    logic [31:0]            busy_r;
    // Copy of the loaded list for the reference model
    copper_pkg::insn_word_t prog [`COPPER_LIST_DEPTH];
    copper_pkg::pos_t       pos_h [8];
    copper_pkg::pos_t       pos_v [8];
    int                     phase_end [8];
    // Expected writes as {addr, data}
    logic [31:0]            exp_q [$];
    logic [31:0]            exp_w;
    int                     total_exp = 0;
    int                     n_checked = 0;
    logic                   prev_en = 1'b0;

    copper_top u_copper_top (
        .clk            (clk),
        .copp_reset     (copp_reset),
        .list_wr_en_i   (list_wr_en),
        .list_wr_addr_i (list_wr_addr),
        .list_wr_data_i (list_wr_data),
        .ctrl_wr_i      (ctrl_wr),
        .h_count_i      (h_cnt),
        .v_count_i      (v_cnt),
        .xr_reg_busy_i  (xr_reg_busy),
        .color_busy_i   (color_busy),
        .xr_wr_o        (xr_wr)
    );

    always #5 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    // WAIT and SKIP layout
    function automatic copper_pkg::insn_word_t pos_word(input logic [3:0] op,
            input copper_pkg::pos_t v, input copper_pkg::pos_t h,
            input logic ign_v, input logic ign_h);
        return {op, 1'b0, v, 1'b0, h, 2'b00, ign_h, ign_v};
    endfunction

    function automatic copper_pkg::insn_word_t jmp_word(input copper_pkg::pc_t target);
        return {`COPPER_OP_JMP, 1'b0, target, 17'd0};
    endfunction

    function automatic copper_pkg::insn_word_t rand_move(input logic allow_nop);
        logic [31:0]            r;
        logic [31:0]            d;
        copper_pkg::insn_word_t w;
        r = $random(seed);
        d = $random(seed);
        w = {r[0] ? `COPPER_OP_MOVEP : `COPPER_OP_MOVER, 4'h0, r[15:8], d[15:0]};
        // About a quarter become undefined opcodes
        if (allow_nop && r[2:1] == 2'b11) begin
            w[31:28] = r[3] ? 4'h7 : 4'hF;
        end
        return w;
    endfunction

    function automatic void set_pos(input int idx, input int h, input int v);
        pos_h[idx] = h;
        pos_v[idx] = v;
    endfunction

    // Walks the list from init_pc with one static beam position per phase
    function automatic void ref_run(input copper_pkg::pc_t init_pc, input int npos);
        copper_pkg::pc_t        pc;
        copper_pkg::insn_word_t w;
        logic                   met;
        logic                   halted;
        logic                   blocked;
        int                     steps;
        pc     = init_pc;
        halted = 1'b0;
        for (int p = 0; p < npos; p++) begin
            blocked = 1'b0;
            steps   = 0;
            while (!halted && !blocked && steps < 64) begin
                w     = prog[pc];
                steps = steps + 1;
                // An ignored axis always counts as reached
                met = (w[0] || pos_v[p] >= w[26:16]) && (w[1] || pos_h[p] >= w[14:4]);
                case (w[31:28])
                    `COPPER_OP_WAIT: begin
                        if (w[1:0] == 2'b11) begin
                            halted = 1'b1;
                        end else if (met) begin
                            pc = pc + 1'b1;
                        end else begin
                            blocked = 1'b1;
                        end
                    end
                    `COPPER_OP_SKIP: pc = met ? pc + 2'd2 : pc + 1'b1;
                    `COPPER_OP_JMP:  pc = w[26:17];
                    `COPPER_OP_MOVER, `COPPER_OP_MOVEP: begin
                        exp_q.push_back({(w[31:28] == `COPPER_OP_MOVEP) ?
                                         `COPPER_XR_COLOR_BASE : 8'h00, w[23:16], w[15:0]});
                        total_exp = total_exp + 1;
                        pc        = pc + 1'b1;
                    end
                    // Undefined opcode runs as NOP
                    default: pc = pc + 1'b1;
                endcase
            end
            phase_end[p] = total_exp;
        end
    endfunction

    task automatic set_beam(input copper_pkg::pos_t h, input copper_pkg::pos_t v);
        @(posedge clk);
        #1;
        h_cnt = h;
        v_cnt = v;
    endtask

    // Free-running beam with line and frame wrap
    task automatic run_beam(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            if (h_cnt == `COPPER_H_TOTAL - 1) begin
                h_cnt = '0;
                v_cnt = (v_cnt == RESTART_V) ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt = h_cnt + 1'b1;
            end
        end
    endtask

    task automatic load_word(input copper_pkg::pc_t addr, input copper_pkg::insn_word_t w);
        @(posedge clk);
        #1;
        list_wr_en   = 1'b1;
        list_wr_addr = addr;
        list_wr_data = w;
        prog[addr]   = w;
        @(posedge clk);
        #1;
        list_wr_en = 1'b0;
    endtask

    task automatic start_frame(input logic en, input copper_pkg::pc_t init_pc);
        set_beam(RESTART_H, RESTART_V);
        @(posedge clk);
        #1;
        ctrl_wr.wr      = 1'b1;
        ctrl_wr.reg_num = `COPPER_XR_COPP_CTRL;
        ctrl_wr.data    = {en, 5'b0, init_pc};
        @(posedge clk);
        #1;
        ctrl_wr = '0;
        // Restart holds the sequencer in INIT while the beam sits here
        repeat (2) @(posedge clk);
    endtask

    task automatic wait_writes(input int target);
        int cycles;
        cycles = 0;
        while (n_checked < target) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > 4000) begin
                fail_now("timeout while waiting for the expected XR writes");
            end
        end
    endtask

    // Quiet window in which a parked copper writes nothing
    task automatic settle_and_count(input int target);
        repeat (60) @(posedge clk);
        assert (n_checked == target)
            else fail_now("more XR writes arrived than the program should produce");
    endtask

    task automatic run_program(input copper_pkg::pc_t init_pc, input int npos);
        ref_run(init_pc, npos);
        start_frame(1'b1, init_pc);
        for (int p = 0; p < npos; p++) begin
            set_beam(pos_h[p], pos_v[p]);
            wait_writes(phase_end[p]);
            settle_and_count(phase_end[p]);
        end
    endtask

    // Random target busy levels
    always @(posedge clk) begin
        #1;
        if (busy_on) begin
            busy_r      = $random(seed);
            xr_reg_busy = busy_r[0];
            color_busy  = busy_r[1];
        end else begin
            xr_reg_busy = 1'b0;
            color_busy  = 1'b0;
        end
    end

    // XR write checker
    always @(negedge clk) begin
        if (!copp_reset && xr_wr.en) begin
            assert (!prev_en) else fail_now("XR write enable stayed high for two cycles");
            assert (exp_q.size() > 0) else fail_now("XR write arrived when none was expected");
            exp_w     = exp_q.pop_front();
            n_checked = n_checked + 1;
            assert (xr_wr.addr == exp_w[31:16])
                else fail_now($sformatf("error: xr_wr_o.addr is %h, expected %h",
                                        xr_wr.addr, exp_w[31:16]));
            assert (xr_wr.data == exp_w[15:0])
                else fail_now($sformatf("error: xr_wr_o.data is %h, expected %h",
                                        xr_wr.data, exp_w[15:0]));
        end
        prev_en = xr_wr.en;
    end

    initial begin
        repeat (100000) @(posedge clk);
        fail_now("simulation ran past its overall cycle limit");
    end

    initial begin
        seed         = 32'h18b4b91d;
        clk          = 1'b0;
        copp_reset   = 1'b1;
        list_wr_en   = 1'b0;
        list_wr_addr = '0;
        list_wr_data = '0;
        ctrl_wr      = '0;
        h_cnt        = '0;
        v_cnt        = '0;
        xr_reg_busy  = 1'b0;
        color_busy   = 1'b0;
        busy_on      = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        copp_reset = 1'b0;

        // Random MOVER and MOVEP with undefined opcodes between them
        for (int i = 0; i < 12; i++) begin
            load_word(i, rand_move(1'b1));
        end
        load_word(12, HALT_WORD);
        set_pos(0, 100, 100);
        run_program(0, 1);

        // WAIT with each flag combination as the beam steps up to each target
        // Each ignored coordinate lies beyond the beam so only its flag lets it pass
        load_word(100, pos_word(`COPPER_OP_WAIT, 50, 300, 1'b0, 1'b0));
        load_word(101, rand_move(1'b0));
        load_word(102, pos_word(`COPPER_OP_WAIT, 60, 700, 1'b0, 1'b1));
        load_word(103, rand_move(1'b0));
        load_word(104, pos_word(`COPPER_OP_WAIT, 400, 500, 1'b1, 1'b0));
        load_word(105, rand_move(1'b0));
        load_word(106, HALT_WORD);
        load_word(107, rand_move(1'b0));
        set_pos(0, 0, 0);
        set_pos(1, 299, 50);
        set_pos(2, 300, 50);
        set_pos(3, 0, 60);
        set_pos(4, 500, 61);
        set_pos(5, 799, 300);
        run_program(100, 6);

        // First SKIP reached, second one not
        load_word(200, pos_word(`COPPER_OP_SKIP, 100, 100, 1'b0, 1'b0));
        load_word(201, rand_move(1'b0));
        load_word(202, rand_move(1'b0));
        load_word(203, pos_word(`COPPER_OP_SKIP, 400, 0, 1'b0, 1'b0));
        load_word(204, rand_move(1'b0));
        load_word(205, HALT_WORD);
        set_pos(0, 150, 300);
        run_program(200, 1);

        // JMP over a move
        load_word(300, rand_move(1'b0));
        load_word(301, jmp_word(310));
        load_word(302, rand_move(1'b0));
        load_word(303, HALT_WORD);
        load_word(310, rand_move(1'b0));
        load_word(311, rand_move(1'b0));
        load_word(312, HALT_WORD);
        set_pos(0, 10, 10);
        run_program(300, 1);

        // Moves against random busy levels
        for (int i = 0; i < 16; i++) begin
            load_word(500 + i, rand_move(1'b0));
        end
        load_word(516, HALT_WORD);
        set_pos(0, 20, 20);
        @(negedge clk);
        busy_on = 1'b1;
        run_program(500, 1);
        @(negedge clk);
        busy_on = 1'b0;

        // Disabled copper stays silent through a restart
        for (int i = 0; i < 4; i++) begin
            load_word(400 + i, rand_move(1'b0));
        end
        load_word(404, HALT_WORD);
        start_frame(1'b0, 400);
        run_beam(40);
        settle_and_count(total_exp);

        // Re-enabled copper starts the frame at the new initial PC
        for (int i = 0; i < 4; i++) begin
            load_word(420 + i, rand_move(1'b0));
        end
        load_word(424, HALT_WORD);
        set_pos(0, 0, 0);
        ref_run(420, 1);
        start_frame(1'b1, 420);
        run_beam(30);
        wait_writes(phase_end[0]);
        settle_and_count(phase_end[0]);

        if (exp_q.size() == 0 && n_checked == total_exp) begin
            $display("No errors");
            $finish;
        end else begin
            fail_now("expected XR writes were still outstanding at the end of the test");
        end
    end

endmodule

// ==== rtl/copper_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Copper top level
// Connects the list memory, decoder, sequencer and result stage
// Host loads the list and control register, beam counts come from the
// video timing generator
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module copper_top (
    input  logic                   clk,
    input  logic                   copp_reset,
    // Host program port
    input  logic                   list_wr_en_i,
    input  copper_pkg::pc_t        list_wr_addr_i,
    input  copper_pkg::insn_word_t list_wr_data_i,
    // Host register port
    input  copper_pkg::ctrl_wr_t   ctrl_wr_i,
    // Beam position
    input  copper_pkg::pos_t       h_count_i,
    input  copper_pkg::pos_t       v_count_i,
    // Target busy levels
    input  logic                   xr_reg_busy_i,
    input  logic                   color_busy_i,
    // XR write bus
    output copper_pkg::xr_wr_t     xr_wr_o
);

    logic                     rd_en;
    copper_pkg::pc_t          rd_addr;
    copper_pkg::insn_word_t   rd_data;
    logic                     insn_latch;
    copper_pkg::copper_insn_t insn;
    logic                     move_issue;
    logic                     move_accept;

    copper_list_ram u_list_ram (
        .clk       (clk),
        .wr_en_i   (list_wr_en_i),
        .wr_addr_i (list_wr_addr_i),
        .wr_data_i (list_wr_data_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    copper_decode u_decode (
        .clk        (clk),
        .copp_reset (copp_reset),
        .latch_i    (insn_latch),
        .rd_data_i  (rd_data),
        .insn_o     (insn)
    );

    copper_execute u_execute (
        .clk           (clk),
        .copp_reset    (copp_reset),
        .ctrl_wr_i     (ctrl_wr_i),
        .h_count_i     (h_count_i),
        .v_count_i     (v_count_i),
        .insn_i        (insn),
        .move_accept_i (move_accept),
        .rd_en_o       (rd_en),
        .rd_addr_o     (rd_addr),
        .insn_latch_o  (insn_latch),
        .move_issue_o  (move_issue)
    );

    copper_result u_result (
        .clk           (clk),
        .copp_reset    (copp_reset),
        .insn_i        (insn),
        .move_issue_i  (move_issue),
        .xr_reg_busy_i (xr_reg_busy_i),
        .color_busy_i  (color_busy_i),
        .move_accept_o (move_accept),
        .xr_wr_o       (xr_wr_o)
    );

endmodule

// ==== rtl/copper_result.sv ====
////////////////////////////////////////////////////////////////////////////
// Copper result stage
// Grants a move once its target is free and issues it as a one-cycle
// write on the XR bus
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module copper_result (
    input  logic                     clk,
    input  logic                     copp_reset,
    input  copper_pkg::copper_insn_t insn_i,
    // Move request from the sequencer, held while stalled
    input  logic                     move_issue_i,
    // Target busy levels
    input  logic                     xr_reg_busy_i,
    input  logic                     color_busy_i,
    output logic                     move_accept_o,
    output copper_pkg::xr_wr_t       xr_wr_o
);

    logic              target_busy;
    logic              wr_en_q;
    copper_pkg::word_t wr_addr_q;
    copper_pkg::word_t wr_data_q;

    // Busy level of the selected target
    assign target_busy   = insn_i.move_to_color ? color_busy_i : xr_reg_busy_i;
    assign move_accept_o = move_issue_i && !target_busy;

    // Write strobe, high for the cycle after acceptance
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= move_accept_o;
        end
    end

    // Write payload
    always_ff @(posedge clk) begin
        if (move_accept_o) begin
            wr_addr_q <= insn_i.move_addr;
            wr_data_q <= insn_i.move_data;
        end
    end

    assign xr_wr_o.en   = wr_en_q;
    assign xr_wr_o.addr = wr_addr_q;
    assign xr_wr_o.data = wr_data_q;

    // Sequencer leaves EXEC on a grant, so writes never come back to back
    a_wr_single_cycle: assert property (@(posedge clk) disable iff (copp_reset)
        xr_wr_o.en |=> !xr_wr_o.en);

endmodule

// ==== rtl/copper_execute.sv ====
////////////////////////////////////////////////////////////////////////////
// Copper sequencer: control register, frame restart, fetch and execute
// state machine and program counter
// Resolves WAIT, SKIP and JMP itself and hands moves to the result stage
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "copper_defines.svh"

module copper_execute (
    input  logic                     clk,
    input  logic                     copp_reset,
    // Host register port
    input  copper_pkg::ctrl_wr_t     ctrl_wr_i,
    // Beam position
    input  copper_pkg::pos_t         h_count_i,
    input  copper_pkg::pos_t         v_count_i,
    // Decoded instruction and move grant
    input  copper_pkg::copper_insn_t insn_i,
    input  logic                     move_accept_i,
    // List memory fetch
    output logic                     rd_en_o,
    output copper_pkg::pc_t          rd_addr_o,
    output logic                     insn_latch_o,
    output logic                     move_issue_o
);

    // Restart position, a few pixels before the end of the last line
    localparam copper_pkg::pos_t RESTART_H =
        copper_pkg::pos_t'(`COPPER_H_TOTAL - `COPPER_RESTART_H_OFFSET);
    localparam copper_pkg::pos_t RESTART_V = copper_pkg::pos_t'(`COPPER_V_TOTAL - 1);

    copper_pkg::exec_state_t state_q;
    copper_pkg::pc_t         pc_q;
    copper_pkg::pc_t         pc_skip_q;
    copper_pkg::pc_t         init_pc_q;
    logic                    copper_en_q;
    logic                    rd_en_q;
    logic                    v_reached_q;
    logic                    h_reached_q;
    logic                    frame_restart;
    logic                    pos_met;
    logic                    wait_done;

    // Control register: bit 15 enable, bits 9:0 initial PC
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            copper_en_q <= 1'b0;
            init_pc_q   <= '0;
        end else if (ctrl_wr_i.wr && ctrl_wr_i.reg_num == `COPPER_XR_COPP_CTRL) begin
            copper_en_q <= ctrl_wr_i.data[15];
            init_pc_q   <= ctrl_wr_i.data[`COPPER_PC_W-1:0];
        end
    end

    assign frame_restart = (h_count_i == RESTART_H) && (v_count_i == RESTART_V);

    // Position compares, registered in PRECOMP for use in EXEC
    always_ff @(posedge clk) begin
        if (state_q == copper_pkg::ST_PRECOMP) begin
            v_reached_q <= v_count_i >= insn_i.v_pos;
            h_reached_q <= h_count_i >= insn_i.h_pos;
            // PC already points past this instruction
            pc_skip_q   <= pc_q + 1'b1;
        end
    end

    // Each axis passes if reached or ignored
    assign pos_met   = (insn_i.ignore_v || v_reached_q) && (insn_i.ignore_h || h_reached_q);
    // Both flags set waits for the end of frame
    assign wait_done = pos_met && !(insn_i.ignore_v && insn_i.ignore_h);

    // Sequencer
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state_q <= copper_pkg::ST_INIT;
            pc_q    <= '0;
            rd_en_q <= 1'b0;
        end else if (frame_restart) begin
            state_q <= copper_pkg::ST_INIT;
            pc_q    <= init_pc_q;
            rd_en_q <= 1'b0;
        end else begin
            case (state_q)
                copper_pkg::ST_INIT: begin
                    // First fetch of the frame, or after a disable
                    if (copper_en_q) begin
                        state_q <= copper_pkg::ST_FETCH_WAIT;
                        rd_en_q <= 1'b1;
                    end
                end
                copper_pkg::ST_FETCH_WAIT: begin
                    if (copper_en_q) begin
                        state_q <= copper_pkg::ST_LATCH;
                        // RAM still returns the current word next cycle
                        pc_q    <= pc_q + 1'b1;
                    end else begin
                        state_q <= copper_pkg::ST_INIT;
                        rd_en_q <= 1'b0;
                    end
                end
                copper_pkg::ST_LATCH: begin
                    state_q <= copper_pkg::ST_PRECOMP;
                    rd_en_q <= 1'b0;
                end
                copper_pkg::ST_PRECOMP: begin
                    state_q <= copper_pkg::ST_EXEC;
                end
                copper_pkg::ST_EXEC: begin
                    case (insn_i.kind)
                        copper_pkg::KIND_WAIT: begin
                            if (wait_done) begin
                                state_q <= copper_pkg::ST_FETCH_WAIT;
                                rd_en_q <= 1'b1;
                            end else begin
                                // Compare again with fresh counts
                                state_q <= copper_pkg::ST_PRECOMP;
                            end
                        end
                        copper_pkg::KIND_SKIP: begin
                            if (pos_met) begin
                                pc_q <= pc_skip_q;
                            end
                            state_q <= copper_pkg::ST_FETCH_WAIT;
                            rd_en_q <= 1'b1;
                        end
                        copper_pkg::KIND_JMP: begin
                            pc_q    <= insn_i.jump_pc;
                            state_q <= copper_pkg::ST_FETCH_WAIT;
                            rd_en_q <= 1'b1;
                        end
                        copper_pkg::KIND_MOVE: begin
                            // Stall here while the target is busy
                            if (move_accept_i) begin
                                state_q <= copper_pkg::ST_FETCH_WAIT;
                                rd_en_q <= 1'b1;
                            end
                        end
                        default: begin
                            state_q <= copper_pkg::ST_FETCH_WAIT;
                            rd_en_q <= 1'b1;
                        end
                    endcase
                end
                default: begin
                    state_q <= copper_pkg::ST_INIT;
                    rd_en_q <= 1'b0;
                end
            endcase
        end
    end

    assign rd_en_o      = rd_en_q;
    assign rd_addr_o    = pc_q;
    // Fetched word is on the RAM output during LATCH
    assign insn_latch_o = (state_q == copper_pkg::ST_LATCH);
    assign move_issue_o = (state_q == copper_pkg::ST_EXEC) &&
                          (insn_i.kind == copper_pkg::KIND_MOVE);

    // State register never leaves the encoded set
    a_state_legal: assert property (@(posedge clk) disable iff (copp_reset)
        state_q inside {copper_pkg::ST_INIT, copper_pkg::ST_FETCH_WAIT, copper_pkg::ST_LATCH,
                        copper_pkg::ST_PRECOMP, copper_pkg::ST_EXEC});

endmodule

// ==== rtl/copper_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// Copper instruction register and decoder
// Latches the fetched word on the sequencer's pulse and presents it as
// a classified instruction to the sequencer and the result stage
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "copper_defines.svh"

module copper_decode (
    input  logic                     clk,
    input  logic                     copp_reset,
    input  logic                     latch_i,
    input  copper_pkg::insn_word_t   rd_data_i,
    output copper_pkg::copper_insn_t insn_o
);

    // Opcode 4'hF is undefined, so this word runs as a NOP
    localparam copper_pkg::insn_word_t NOP_WORD = 32'hF000_0000;

    copper_pkg::insn_word_t ir_q;
    copper_pkg::insn_kind_t kind;
    logic [3:0]             opcode;
    logic                   is_color;

    // Instruction register
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            ir_q <= NOP_WORD;
        end else if (latch_i) begin
            ir_q <= rd_data_i;
        end
    end

    assign opcode = ir_q[31:28];

    // Opcode classification
    always_comb begin
        kind     = copper_pkg::KIND_NOP;
        is_color = 1'b0;
        case (opcode)
            `COPPER_OP_WAIT:  kind = copper_pkg::KIND_WAIT;
            `COPPER_OP_SKIP:  kind = copper_pkg::KIND_SKIP;
            `COPPER_OP_JMP:   kind = copper_pkg::KIND_JMP;
            `COPPER_OP_MOVER: kind = copper_pkg::KIND_MOVE;
            `COPPER_OP_MOVEP: begin
                kind     = copper_pkg::KIND_MOVE;
                is_color = 1'b1;
            end
            // Unknown opcodes fall through as NOP
            default: kind = copper_pkg::KIND_NOP;
        endcase
    end

    // Field extraction
    always_comb begin
        insn_o.kind          = kind;
        insn_o.ignore_v      = ir_q[0];
        insn_o.ignore_h      = ir_q[1];
        insn_o.v_pos         = ir_q[26:16];
        insn_o.h_pos         = ir_q[14:4];
        // JMP target sits on a 32-bit boundary
        insn_o.jump_pc       = ir_q[26:17];
        insn_o.move_to_color = is_color;
        // MOVER targets XR registers, MOVEP lands in colour memory
        insn_o.move_addr     = {is_color ? `COPPER_XR_COLOR_BASE : 8'h00, ir_q[23:16]};
        insn_o.move_data     = ir_q[15:0];
    end

endmodule

// ==== rtl/copper_list_ram.sv ====
////////////////////////////////////////////////////////////////////////////
// Copper program memory of 32-bit instruction words
// Host loads the program through the write port, the sequencer
// fetches through the registered read port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "copper_defines.svh"

module copper_list_ram (
    input  logic                   clk,
    // Host write port
    input  logic                   wr_en_i,
    input  copper_pkg::pc_t        wr_addr_i,
    input  copper_pkg::insn_word_t wr_data_i,
    // Sequencer read port
    input  logic                   rd_en_i,
    input  copper_pkg::pc_t        rd_addr_i,
    output copper_pkg::insn_word_t rd_data_o
);

    // List storage
    copper_pkg::insn_word_t mem [`COPPER_LIST_DEPTH];

    // Host write
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Registered read
    // Output holds its last word while the strobe is low
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// ==== rtl/copper_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared types of the copper: vector typedefs, sequencer states and
// the structs passed between the decoder, sequencer and result stage
// Referenced by scoped names from every copper module
////////////////////////////////////////////////////////////////////////////
`include "copper_defines.svh"

package copper_pkg;

    // Plain vectors with a meaning
    typedef logic [`COPPER_PC_W-1:0]  pc_t;
    typedef logic [`COPPER_POS_W-1:0] pos_t;
    typedef logic [15:0]              word_t;
    typedef logic [31:0]              insn_word_t;

    // Instruction class after decode
    typedef logic [2:0] insn_kind_t;
    localparam insn_kind_t KIND_WAIT = 3'd0;
    localparam insn_kind_t KIND_SKIP = 3'd1;
    localparam insn_kind_t KIND_JMP  = 3'd2;
    localparam insn_kind_t KIND_MOVE = 3'd3;
    localparam insn_kind_t KIND_NOP  = 3'd4;

    // Sequencer states
    typedef enum logic [2:0] {
        ST_INIT       = 3'd0,
        ST_FETCH_WAIT = 3'd1,
        ST_LATCH      = 3'd2,
        ST_PRECOMP    = 3'd3,
        ST_EXEC       = 3'd4
    } exec_state_t;

    // Decoded instruction
    typedef struct packed {
        insn_kind_t kind;
        logic       ignore_v;
        logic       ignore_h;
        pos_t       v_pos;
        pos_t       h_pos;
        pc_t        jump_pc;
        // Set for MOVEP, clear for MOVER
        logic       move_to_color;
        word_t      move_addr;
        word_t      move_data;
    } copper_insn_t;

    // Host register write
    typedef struct packed {
        logic                          wr;
        logic [`COPPER_REG_NUM_W-1:0]  reg_num;
        word_t                         data;
    } ctrl_wr_t;

    // XR bus write
    typedef struct packed {
        logic  en;
        word_t addr;
        word_t data;
    } xr_wr_t;

endpackage

// ==== rtl/copper_defines.svh ====
////////////////////////////////////////////////////////////////////////////
// Shared constants for the copper display-list coprocessor
// Frame geometry, field widths, opcode codes and target address bases
// Include wherever a constant is needed
////////////////////////////////////////////////////////////////////////////
`ifndef COPPER_DEFINES_SVH
`define COPPER_DEFINES_SVH

// Frame geometry of the video timing generator
`define COPPER_H_TOTAL           800
`define COPPER_V_TOTAL           525
// Restart fires this many pixels before the end of the last line
`define COPPER_RESTART_H_OFFSET  4

// List memory and field widths
`define COPPER_LIST_DEPTH        1024
`define COPPER_PC_W              10
`define COPPER_POS_W             11
`define COPPER_REG_NUM_W         6

// Control register number on the host register port
`define COPPER_XR_COPP_CTRL      1

// Opcodes in bits 31:28 of an instruction word
`define COPPER_OP_WAIT           4'h0
`define COPPER_OP_SKIP           4'h2
`define COPPER_OP_JMP            4'h4
`define COPPER_OP_MOVER          4'h9
`define COPPER_OP_MOVEP          4'hB

// High byte of the colour memory XR address
`define COPPER_XR_COLOR_BASE     8'h80

`endif
